//--- axi_cache_bridge.f
source/axi_bridge_pkg.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/axi_cache_bridge.sv
tb/axi_slave_model.sv
tb/tb_axi_cache_bridge.sv

//--- axi_cache_bridge.sh
#!/bin/sh
# build and run the bridge regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_axi_cache_bridge \
	-f axi_cache_bridge.f \
	-Mdir obj_dir -o sim_axi_cache_bridge

# the simulator may exit non-zero on failure, the log decides
./obj_dir/sim_axi_cache_bridge 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

//--- tb/tb_axi_cache_bridge.sv
`timescale 1ns/1ps

module tb_axi_cache_bridge
	import axi_bridge_pkg::*;
;

	localparam int N_TRANS = 8;
	localparam int WATCHDOG_CYCLES = N_TRANS * 16 * 8 + 200;

	logic clk;
	logic rst;
	logic inst_rd_req, inst_rd_rdy, data_rd_req, data_rd_rdy, wr_req, wr_rdy;
	cache_rd_req_t inst_rd, data_rd;
	cache_wr_req_t wr;
	cache_ret_t inst_ret, data_ret;
	logic arvalid, arready, rvalid, rready, awvalid, awready;
	logic wvalid, wready, bvalid, bready;
	axi_ar_t ar;
	axi_aw_t aw;
	axi_r_t r;
	axi_w_t w;
	axi_b_t b;

	logic [31:0] exp_mem [0:1023]; // what memory should hold
	axi_ar_t exp_ar_arr [0:7];
	axi_aw_t exp_aw_arr [0:7];
	int n_ar, n_aw, ar_idx, aw_idx;
	axi_ar_t exp_ar;
	axi_aw_t exp_aw;
	logic [LINE_W_MAX-1:0] wr_line_exp;
	logic [3:0] wr_strb_exp;

	logic [9:0] inst_ptr, data_ptr;
	logic [3:0] inst_beat, data_beat, inst_len, data_len, w_beat, wr_len;
	logic inst_busy, data_busy;
	int inst_done, data_done, wr_done;
	logic [31:0] inst_exp, data_exp, exp_wdata;

	axi_cache_bridge #(.LINE_WORDS(16)) i_dut (.*);

	axi_slave_model u_slave (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 40);
		$display("Timeout: the bridge did not finish its transactions in time");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	assign exp_ar = exp_ar_arr[ar_idx];
	assign exp_aw = exp_aw_arr[aw_idx];
	assign inst_exp = exp_mem[inst_ptr];
	assign data_exp = exp_mem[data_ptr];
	assign exp_wdata = 32'(wr_line_exp >> {w_beat, 5'd0});

	// scoreboard pointers, expectations come from the queued requests
	always @(posedge clk)
	begin
		if (!rst)
		begin
			{ar_idx, aw_idx, inst_done, data_done, wr_done} <= '0;
			{inst_busy, data_busy, w_beat} <= '0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				ar_idx <= ar_idx + 1;
				if (exp_ar.id == ID_INST)
				begin
					inst_ptr <= exp_ar.addr[11:2];
					inst_beat <= 4'd0;
					inst_len <= exp_ar.len;
					inst_busy <= 1'b1;
				end
				else
				begin
					data_ptr <= exp_ar.addr[11:2];
					data_beat <= 4'd0;
					data_len <= exp_ar.len;
					data_busy <= 1'b1;
				end
			end
			if (inst_ret.valid)
			begin
				inst_ptr <= inst_ptr + 10'd1;
				inst_beat <= inst_beat + 4'd1;
				if (inst_ret.last)
				begin
					inst_busy <= 1'b0;
					inst_done <= inst_done + 1;
				end
			end
			if (data_ret.valid)
			begin
				data_ptr <= data_ptr + 10'd1;
				data_beat <= data_beat + 4'd1;
				if (data_ret.last)
				begin
					data_busy <= 1'b0;
					data_done <= data_done + 1;
				end
			end
			if (awvalid && awready)
			begin
				aw_idx <= aw_idx + 1;
				wr_len <= exp_aw.len;
				w_beat <= 4'd0;
			end
			if (wvalid && wready)
				w_beat <= w_beat + 4'd1;
			if (bvalid && bready)
				wr_done <= wr_done + 1;
		end
	end

	task automatic report_value(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		$display("Error %s expected %h actual %h", name, exp_v, act_v);
		$display("Regression failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_event(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "protocol violation");
	endtask

	a_reset: assert property (@(posedge clk) $rose(rst) |-> !arvalid && !awvalid && !wvalid
		&& !rready && !bready && inst_rd_rdy && data_rd_rdy && wr_rdy)
		else report_event("bridge outputs are not idle right after reset");
	a_ar: assert property (@(posedge clk) disable iff (!rst) arvalid && arready |-> ar == exp_ar)
		else report_value("ar_payload", 64'(exp_ar), 64'(ar));
	a_prio: assert property (@(posedge clk) disable iff (!rst) data_rd_req |-> !inst_rd_rdy)
		else report_event("instruction read offered while the data cache requests");
	a_inst_data: assert property (@(posedge clk) disable iff (!rst)
		inst_ret.valid |-> inst_ret.data == inst_exp)
		else report_value("inst_read_data", 64'(inst_exp), 64'(inst_ret.data));
	a_inst_last: assert property (@(posedge clk) disable iff (!rst)
		inst_ret.valid |-> inst_ret.last == (inst_beat == inst_len))
		else report_value("inst_read_last", 64'(inst_beat == inst_len), 64'(inst_ret.last));
	a_inst_route: assert property (@(posedge clk) disable iff (!rst) inst_ret.valid |-> inst_busy)
		else report_event("instruction return with no instruction read in flight");
	a_data_data: assert property (@(posedge clk) disable iff (!rst)
		data_ret.valid |-> data_ret.data == data_exp)
		else report_value("data_read_data", 64'(data_exp), 64'(data_ret.data));
	a_data_last: assert property (@(posedge clk) disable iff (!rst)
		data_ret.valid |-> data_ret.last == (data_beat == data_len))
		else report_value("data_read_last", 64'(data_beat == data_len), 64'(data_ret.last));
	a_data_route: assert property (@(posedge clk) disable iff (!rst) data_ret.valid |-> data_busy)
		else report_event("data return with no data read in flight");
	a_aw: assert property (@(posedge clk) disable iff (!rst) awvalid && awready |-> aw == exp_aw)
		else report_value("aw_payload", 64'(exp_aw), 64'(aw));
	a_wdata: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> w.data == exp_wdata)
		else report_value("write_data", 64'(exp_wdata), 64'(w.data));
	a_wstrb: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> w.strb == wr_strb_exp)
		else report_value("write_strobe", 64'(wr_strb_exp), 64'(w.strb));
	a_wlast: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> w.last == (w_beat == wr_len))
		else report_value("write_last", 64'(w_beat == wr_len), 64'(w.last));
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar))
		else report_event("read address changed while stalled");
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(aw))
		else report_event("write address changed while stalled");
	a_w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(w))
		else report_event("write data changed while stalled");

	function automatic axi_ar_t make_addr(input axi_id_e id, input logic [31:0] addr,
		input logic unc);
		axi_ar_t a;
		a.id = id;
		a.addr = addr;
		a.len = unc ? 4'd0 : 4'd15;
		a.size = 3'd2;
		a.burst = unc ? BURST_FIXED : BURST_INCR;
		return a;
	endfunction

	task automatic start_read(input logic is_data, input logic [31:0] addr, input logic unc);
		@(negedge clk);
		exp_ar_arr[n_ar] = make_addr(is_data ? ID_DATA : ID_INST, addr, unc);
		n_ar++;
		if (is_data)
		begin
			data_rd = '{size: 3'd2, addr: addr, uncached: unc};
			data_rd_req = 1'b1;
		end
		else
		begin
			inst_rd = '{size: 3'd2, addr: addr, uncached: 1'b0};
			inst_rd_req = 1'b1;
		end
		@(posedge clk);
		while (!(is_data ? data_rd_rdy : inst_rd_rdy))
			@(posedge clk);
		@(negedge clk);
		if (is_data)
			data_rd_req = 1'b0;
		else
			inst_rd_req = 1'b0;
	endtask

	// both caches ask in the same cycle, data goes first
	task automatic start_both(input logic [31:0] inst_addr, input logic [31:0] data_addr);
		@(negedge clk);
		exp_ar_arr[n_ar] = make_addr(ID_DATA, data_addr, 1'b0);
		exp_ar_arr[n_ar + 1] = make_addr(ID_INST, inst_addr, 1'b0);
		n_ar += 2;
		data_rd = '{size: 3'd2, addr: data_addr, uncached: 1'b0};
		inst_rd = '{size: 3'd2, addr: inst_addr, uncached: 1'b0};
		data_rd_req = 1'b1;
		inst_rd_req = 1'b1;
		@(posedge clk);
		while (!data_rd_rdy)
			@(posedge clk);
		@(negedge clk);
		data_rd_req = 1'b0;
		@(posedge clk);
		while (!inst_rd_rdy)
			@(posedge clk);
		@(negedge clk);
		inst_rd_req = 1'b0;
	endtask

	task automatic write_line(input logic [31:0] addr, input logic unc, input logic [3:0] strb,
		input logic [LINE_W_MAX-1:0] line);
		int target;
		target = wr_done + 1;
		@(negedge clk);
		exp_aw_arr[n_aw] = make_addr(ID_DATA, addr, unc);
		n_aw++;
		wr_line_exp = line;
		wr_strb_exp = strb;
		wr = '{size: 3'd2, addr: addr, wstrb: strb, uncached: unc, line: line};
		wr_req = 1'b1;
		@(posedge clk);
		while (!wr_rdy)
			@(posedge clk);
		@(negedge clk);
		wr_req = 1'b0;
		wait (wr_done == target);
		if (unc)
		begin
			for (int k = 0; k < 4; k++)
				if (strb[k])
					exp_mem[addr[11:2]][8*k +: 8] = line[8*k +: 8];
		end
		else
		begin
			for (int i = 0; i < 16; i++)
				exp_mem[addr[11:2] + 10'(i)] = line[32*i +: 32];
		end
	endtask

	initial
	begin
		logic [LINE_W_MAX-1:0] line;
		for (int i = 0; i < 1024; i++)
			exp_mem[i] = 32'(i * 4) ^ 32'hA5A5_0000; // slave memory fill rule
		n_ar = 0;
		n_aw = 0;
		rst = 1'b0;
		{inst_rd_req, data_rd_req, wr_req} = '0;
		inst_rd = '0;
		data_rd = '0;
		wr = '0;
		wr_line_exp = '0;
		wr_strb_exp = '0;
		repeat (5) @(negedge clk);
		rst = 1'b1;

		start_read(1'b0, 32'h0000_0100, 1'b0); // cached instruction line
		wait (inst_done == 1);
		start_read(1'b1, 32'h0000_0204, 1'b1); // uncached data word
		wait (data_done == 1);
		start_both(32'h0000_0300, 32'h0000_0400);
		wait (inst_done == 2 && data_done == 2);

		for (int i = 0; i < 16; i++)
			line[32*i +: 32] = 32'hC0DE_0000 | 32'(i * 17);
		write_line(32'h0000_0800, 1'b0, 4'hF, line); // write-back, then read it again
		start_read(1'b1, 32'h0000_0800, 1'b0);
		wait (data_done == 3);

		line = '0;
		line[31:0] = 32'h1234_5678;
		line[63:32] = 32'hDEAD_BEEF; // must not be sent
		write_line(32'h0000_0C08, 1'b1, 4'b0011, line);
		start_read(1'b1, 32'h0000_0C08, 1'b1);
		wait (data_done == 4);

		repeat (4) @(negedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

//--- tb/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model
	import axi_bridge_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic arvalid,
	output logic arready,
	input axi_ar_t ar,
	output logic rvalid,
	output axi_r_t r,
	input logic rready,

	input logic awvalid,
	output logic awready,
	input axi_aw_t aw,
	input logic wvalid,
	output logic wready,
	input axi_w_t w,
	output logic bvalid,
	output axi_b_t b,
	input logic bready
);

	logic [31:0] mem [0:1023]; // 4 KiB of words
	logic [31:0] rnd;

	logic rd_busy;
	logic [9:0] rd_idx;
	logic [3:0] rd_left; // beats still to send minus one
	axi_id_e rd_id;
	logic rd_incr;

	logic wr_busy;
	logic [9:0] wr_idx;
	logic wr_incr;
	logic b_pend;

	logic r_taken; // a transfer happened at the last rising edge
	logic b_taken;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	initial
	begin
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
		rnd = 32'd32;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		bvalid = 1'b0;
	end

	always_comb
	begin
		r.id = rd_id;
		r.data = mem[rd_idx];
		r.last = (rd_left == 4'd0);
		b.id = ID_DATA;
		b.resp = 2'b00; // always OKAY
	end

	// bookkeeping on the rising edge
	always @(posedge clk)
	begin
		if (!rst)
		begin
			rd_busy <= 1'b0;
			rd_id <= ID_INST;
			rd_idx <= 10'd0;
			rd_left <= 4'd0;
			wr_busy <= 1'b0;
			b_pend <= 1'b0;
			r_taken <= 1'b0;
			b_taken <= 1'b0;
		end
		else
		begin
			r_taken <= rvalid && rready;
			b_taken <= bvalid && bready;
			if (arvalid && arready)
			begin
				rd_busy <= 1'b1;
				rd_idx <= ar.addr[11:2];
				rd_left <= ar.len;
				rd_id <= ar.id;
				rd_incr <= (ar.burst == BURST_INCR);
			end
			if (rvalid && rready)
			begin
				if (r.last)
					rd_busy <= 1'b0;
				else
				begin
					rd_left <= rd_left - 4'd1;
					if (rd_incr)
						rd_idx <= rd_idx + 10'd1;
				end
			end
			if (awvalid && awready)
			begin
				wr_busy <= 1'b1;
				wr_idx <= aw.addr[11:2];
				wr_incr <= (aw.burst == BURST_INCR);
			end
			if (wvalid && wready)
			begin
				for (int k = 0; k < 4; k++)
					if (w.strb[k])
						mem[wr_idx][8*k +: 8] <= w.data[8*k +: 8];
				if (w.last)
				begin
					wr_busy <= 1'b0;
					b_pend <= 1'b1;
				end
				else if (wr_incr)
					wr_idx <= wr_idx + 10'd1;
			end
			if (bvalid && bready)
				b_pend <= 1'b0;
		end
	end

	// handshake outputs change on the falling edge
	always @(negedge clk)
	begin
		rnd = xorshift32(rnd);
		if (!rst)
		begin
			arready <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			arready <= !rd_busy && rnd[0];
			awready <= !wr_busy && !b_pend && rnd[1];
			wready <= wr_busy && rnd[2];
			if (!(rvalid && !r_taken))
				rvalid <= rd_busy && rnd[3]; // once raised, held until taken
			if (!(bvalid && !b_taken))
				bvalid <= b_pend && rnd[4];
		end
	end

endmodule

//--- source/axi_cache_bridge.sv
`timescale 1ns/1ps

module axi_cache_bridge
	import axi_bridge_pkg::*;
#(
	parameter int LINE_WORDS = 16
)
(
	input logic clk,
	input logic rst,

	// instruction cache read
	input logic inst_rd_req,
	input cache_rd_req_t inst_rd,
	output logic inst_rd_rdy,
	output cache_ret_t inst_ret,

	// data cache read
	input logic data_rd_req,
	input cache_rd_req_t data_rd,
	output logic data_rd_rdy,
	output cache_ret_t data_ret,

	// data cache write
	input logic wr_req,
	input cache_wr_req_t wr,
	output logic wr_rdy,

	// AXI master
	output logic arvalid,
	input logic arready,
	output axi_ar_t ar,
	input logic rvalid,
	input axi_r_t r,
	output logic rready,
	output logic awvalid,
	input logic awready,
	output axi_aw_t aw,
	output logic wvalid,
	input logic wready,
	output axi_w_t w,
	input logic bvalid,
	input axi_b_t b,
	output logic bready
);

	// read side, both caches share AR/R
	axi_read_engine #(
		.LINE_WORDS(LINE_WORDS)
	) u_read (
		.clk(clk),
		.rst(rst),
		.inst_rd_req(inst_rd_req),
		.inst_rd(inst_rd),
		.inst_rd_rdy(inst_rd_rdy),
		.inst_ret(inst_ret),
		.data_rd_req(data_rd_req),
		.data_rd(data_rd),
		.data_rd_rdy(data_rd_rdy),
		.data_ret(data_ret),
		.arvalid(arvalid),
		.arready(arready),
		.ar(ar),
		.rvalid(rvalid),
		.r(r),
		.rready(rready)
	);

	// write side, data cache only
	axi_write_engine #(
		.LINE_WORDS(LINE_WORDS)
	) u_write (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.wr(wr),
		.wr_rdy(wr_rdy),
		.awvalid(awvalid),
		.awready(awready),
		.aw(aw),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.b(b),
		.bready(bready)
	);

endmodule

//--- source/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
	import axi_bridge_pkg::*;
#(
	parameter int LINE_WORDS = 16
)
(
	input logic clk,
	input logic rst,

	// data cache write port
	input logic wr_req,
	input cache_wr_req_t wr,
	output logic wr_rdy,

	// AXI write address
	output logic awvalid,
	input logic awready,
	output axi_aw_t aw,

	// AXI write data
	output logic wvalid,
	input logic wready,
	output axi_w_t w,

	// AXI write response
	input logic bvalid,
	input axi_b_t b,
	output logic bready
);

	localparam logic [3:0] LINE_LEN = 4'(LINE_WORDS - 1);

	wr_state_e state;
	wr_state_e state_nxt;

	logic [LINE_W_MAX-1:0] line_q; // shifts down one word per beat
	logic [3:0] wstrb_q;
	logic uncached_q;
	logic [3:0] beat_cnt;

	logic accept;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic last_beat;

	assign accept = (state == WR_IDLE) && wr_req;
	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign b_fire = bvalid && bready;

	// uncached writes are a single beat
	assign last_beat = uncached_q || (beat_cnt == LINE_LEN);

	always_comb
	begin
		state_nxt = state;
		case (state)
			WR_IDLE:
			begin
				if (accept)
					state_nxt = WR_ADDR;
			end
			WR_ADDR:
			begin
				if (aw_fire)
					state_nxt = WR_DATA;
			end
			WR_DATA:
			begin
				if (w_fire && last_beat)
					state_nxt = WR_RESP;
			end
			WR_RESP:
			begin
				if (b_fire)
					state_nxt = WR_IDLE;
			end
			default:
			begin
				state_nxt = WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= WR_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			beat_cnt <= 4'd0;
			uncached_q <= 1'b0;
		end
		else if (accept)
		begin
			beat_cnt <= 4'd0;
			uncached_q <= wr.uncached;
		end
		else if (w_fire)
		begin
			beat_cnt <= beat_cnt + 4'd1;
		end
	end

	// header and line captured on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			aw.id <= ID_DATA;
			aw.addr <= wr.addr;
			aw.size <= wr.size;
			wstrb_q <= wr.wstrb;
			line_q <= wr.line;
			if (wr.uncached)
			begin
				aw.len <= 4'd0;
				aw.burst <= BURST_FIXED;
			end
			else
			begin
				aw.len <= LINE_LEN;
				aw.burst <= BURST_INCR;
			end
		end
		else if (w_fire)
		begin
			line_q <= {{DATA_W{1'b0}}, line_q[LINE_W_MAX-1:DATA_W]};
		end
	end

	assign awvalid = (state == WR_ADDR);
	assign wvalid = (state == WR_DATA);
	assign bready = (state == WR_RESP);
	assign wr_rdy = (state == WR_IDLE);

	always_comb
	begin
		w.data = line_q[DATA_W-1:0]; // low word goes out first
		w.strb = wstrb_q;
		w.last = last_beat;
	end

endmodule

//--- source/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
	import axi_bridge_pkg::*;
#(
	parameter int LINE_WORDS = 16
)
(
	input logic clk,
	input logic rst,

	// instruction cache
	input logic inst_rd_req,
	input cache_rd_req_t inst_rd,
	output logic inst_rd_rdy,
	output cache_ret_t inst_ret,

	// data cache
	input logic data_rd_req,
	input cache_rd_req_t data_rd,
	output logic data_rd_rdy,
	output cache_ret_t data_ret,

	// AXI read address and data
	output logic arvalid,
	input logic arready,
	output axi_ar_t ar,
	input logic rvalid,
	input axi_r_t r,
	output logic rready
);

	localparam logic [3:0] LINE_LEN = 4'(LINE_WORDS - 1);

	rd_state_e state;
	rd_state_e state_nxt;

	logic accept_data;
	logic accept_inst;
	logic ar_fire;
	logic r_fire;
	logic r_to_inst;
	logic r_to_data;

	// data cache wins when both ask
	assign accept_data = (state == RD_IDLE) && data_rd_req;
	assign accept_inst = (state == RD_IDLE) && inst_rd_req && !data_rd_req;

	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	always_comb
	begin
		state_nxt = state;
		case (state)
			RD_IDLE:
			begin
				if (accept_data || accept_inst)
					state_nxt = RD_ADDR;
			end
			RD_ADDR:
			begin
				if (ar_fire)
					state_nxt = RD_DATA;
			end
			RD_DATA:
			begin
				if (r_fire && r.last)
					state_nxt = RD_IDLE; // rdy back next cycle
			end
			default:
			begin
				state_nxt = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= RD_IDLE;
		else
			state <= state_nxt;
	end

	// address payload, held until the AR transfer
	always_ff @(posedge clk)
	begin
		if (accept_data)
		begin
			ar.id <= ID_DATA;
			ar.addr <= data_rd.addr;
			ar.size <= data_rd.size;
			if (data_rd.uncached)
			begin
				ar.len <= 4'd0; // single word
				ar.burst <= BURST_FIXED;
			end
			else
			begin
				ar.len <= LINE_LEN;
				ar.burst <= BURST_INCR;
			end
		end
		else if (accept_inst)
		begin
			ar.id <= ID_INST;
			ar.addr <= inst_rd.addr;
			ar.size <= inst_rd.size;
			ar.len <= LINE_LEN; // always a full line
			ar.burst <= BURST_INCR;
		end
	end

	assign arvalid = (state == RD_ADDR);
	assign rready = (state == RD_DATA);

	assign data_rd_rdy = (state == RD_IDLE);
	assign inst_rd_rdy = (state == RD_IDLE) && !data_rd_req;

	// return routing by rid, no stall possible on the cache side
	assign r_to_inst = r_fire && (r.id == ID_INST);
	assign r_to_data = r_fire && (r.id == ID_DATA);

	always_comb
	begin
		inst_ret.valid = r_to_inst;
		inst_ret.last = r_to_inst && r.last;
		inst_ret.data = r.data;

		data_ret.valid = r_to_data;
		data_ret.last = r_to_data && r.last;
		data_ret.data = r.data;
	end

endmodule

//--- source/axi_bridge_pkg.sv
package axi_bridge_pkg;

	parameter int ADDR_W = 32;
	parameter int DATA_W = 32;
	parameter int LINE_W_MAX = 512; // 16 words, largest line

	// rid/bid tell the two requesters apart
	typedef enum logic [3:0]
	{
		ID_INST = 4'd0,
		ID_DATA = 4'd1
	} axi_id_e;

	typedef enum logic [1:0]
	{
		BURST_FIXED = 2'b00,
		BURST_INCR = 2'b01
	} axi_burst_e;

	typedef enum logic [1:0]
	{
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;

	typedef enum logic [1:0]
	{
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef struct packed
	{
		logic [2:0] size;
		logic [ADDR_W-1:0] addr;
		logic uncached;
	} cache_rd_req_t;

	// write-back line, low word sent first
	typedef struct packed
	{
		logic [2:0] size;
		logic [ADDR_W-1:0] addr;
		logic [3:0] wstrb;
		logic uncached;
		logic [LINE_W_MAX-1:0] line;
	} cache_wr_req_t;

	typedef struct packed
	{
		logic valid;
		logic last;
		logic [DATA_W-1:0] data;
	} cache_ret_t;

	typedef struct packed
	{
		axi_id_e id;
		logic [ADDR_W-1:0] addr;
		logic [3:0] len; // beats minus one
		logic [2:0] size;
		axi_burst_e burst;
	} axi_ar_t;

	typedef axi_ar_t axi_aw_t; // same fields on both address channels

	typedef struct packed
	{
		axi_id_e id;
		logic [DATA_W-1:0] data;
		logic last;
	} axi_r_t;

	typedef struct packed
	{
		logic [DATA_W-1:0] data;
		logic [3:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed
	{
		axi_id_e id;
		logic [1:0] resp;
	} axi_b_t;

endpackage
